/* hdl/rt_defines.svh */
`ifndef RT_DEFINES_SVH
`define RT_DEFINES_SVH

// Number of thread ids carried with a ray.
`define RT_NUM_THREAD 32

// Number of programmable z planes.
`define RT_NUM_PLANE 4

// Signed Q16.16 fixed point.
`define RT_FRAC_BITS 16

// Surface id returned when no plane is hit.
`define RT_MISS_SID 32'hFFFF_FFFF

`endif

/* hdl/rt_pkg.sv */
`include "rt_defines.svh"

package rt_pkg;

  typedef logic signed [31:0] fix_t;  // Q16.16 scalar.

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  typedef logic [$clog2(`RT_NUM_THREAD)-1:0] tid_t;
  typedef logic [$clog2(`RT_NUM_PLANE)-1:0]  pid_t;
  typedef logic [31:0]                       sid_t;

  typedef struct packed {
    tid_t  tid;
    vec3_t orig;
    vec3_t dir;
  } ray_t;

  typedef struct packed {
    vec3_t point;
    vec3_t norm;
    sid_t  sid;
  } hit_t;

  typedef enum logic {IDLE, BUSY} mgr_state_t;

  typedef enum logic [1:0] {C_IDLE, C_DIV, C_NEXT, C_DONE} core_state_t;

endpackage

/* hdl/plane_table.sv */
`timescale 1ns/10ps
`include "rt_defines.svh"

module plane_table (
  input  logic         clk,
  input  logic         rst,
  input  logic         plane_wr,
  input  rt_pkg::pid_t plane_idx,
  input  rt_pkg::fix_t plane_z,
  input  rt_pkg::pid_t rd_idx,
  output rt_pkg::fix_t rd_z
);

  rt_pkg::fix_t z_reg [`RT_NUM_PLANE];  // One z height per plane.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RT_NUM_PLANE; i++) begin
        z_reg[i] <= '0;
      end
    end else if (plane_wr) begin
      z_reg[plane_idx] <= plane_z;
    end
  end

  // Core reads through this port without delay.
  assign rd_z = z_reg[rd_idx];

endmodule

/* hdl/ray_divider.sv */
`timescale 1ns/10ps
`include "rt_defines.svh"

module ray_divider (
  input  logic         clk,
  input  logic         rst,
  input  logic         div_start,
  input  rt_pkg::fix_t div_num,
  input  rt_pkg::fix_t div_den,
  output logic         div_done,
  output rt_pkg::fix_t div_quot
);

  logic [31:0]                 num_mag;
  logic [31:0]                 den_abs;
  logic [31+`RT_FRAC_BITS:0]   scaled;   // Numerator times 2^16.
  logic [31:0]                 rem;      // Partial remainder.
  logic [31:0]                 dvd;      // Dividend bits out, quotient bits in.
  logic [31:0]                 den_mag;
  logic                        neg;
  logic                        active;
  logic                        fin;
  logic [4:0]                  cnt;
  logic [32:0]                 shifted;
  logic [32:0]                 diff;

  assign num_mag = div_num[31] ? -div_num : div_num;
  assign den_abs = div_den[31] ? -div_den : div_den;
  assign scaled  = {{`RT_FRAC_BITS{1'b0}}, num_mag} << `RT_FRAC_BITS;

  // One restoring step per cycle.
  assign shifted = {rem, dvd[31]};
  assign diff    = shifted - {1'b0, den_mag};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rem      <= '0;
      dvd      <= '0;
      den_mag  <= '0;
      neg      <= 1'b0;
      active   <= 1'b0;
      fin      <= 1'b0;
      cnt      <= '0;
      div_done <= 1'b0;
      div_quot <= '0;
    end else begin
      div_done <= 1'b0;
      fin      <= 1'b0;
      if (div_start) begin
        rem     <= 32'(scaled >> 32);  // Upper bits seed the remainder.
        dvd     <= scaled[31:0];
        den_mag <= den_abs;
        neg     <= div_num[31] ^ div_den[31];
        cnt     <= '0;
        active  <= 1'b1;
      end else if (active) begin
        if (!diff[32]) begin
          rem <= diff[31:0];
          dvd <= {dvd[30:0], 1'b1};
        end else begin
          rem <= shifted[31:0];
          dvd <= {dvd[30:0], 1'b0};
        end
        cnt <= cnt + 5'd1;
        if (cnt == 5'd31) begin
          active <= 1'b0;
          fin    <= 1'b1;
        end
      end else if (fin) begin
        div_done <= 1'b1;
        div_quot <= neg ? -dvd : dvd;  // Truncates toward zero.
      end
    end
  end

endmodule

/* hdl/intersect_core.sv */
`timescale 1ns/10ps
`include "rt_defines.svh"

module intersect_core (
  input  logic         clk,
  input  logic         rst,
  input  logic         core_start,
  input  rt_pkg::ray_t ray,
  input  rt_pkg::fix_t rd_z,
  input  logic         div_done,
  input  rt_pkg::fix_t div_quot,
  output rt_pkg::pid_t rd_idx,
  output logic         div_start,
  output rt_pkg::fix_t div_num,
  output rt_pkg::fix_t div_den,
  output logic         core_done,
  output rt_pkg::hit_t core_hit
);

  localparam rt_pkg::fix_t FIX_ONE  = rt_pkg::fix_t'(1 << `RT_FRAC_BITS);
  localparam rt_pkg::pid_t LAST_IDX = rt_pkg::pid_t'(`RT_NUM_PLANE - 1);

  rt_pkg::core_state_t state;
  rt_pkg::pid_t        idx;
  rt_pkg::pid_t        best_idx;
  rt_pkg::fix_t        best_t;
  rt_pkg::fix_t        best_z;
  rt_pkg::fix_t        dz;
  rt_pkg::fix_t        oz;
  logic                found;

  // Origin plus direction times t, product rescaled to Q16.16.
  function automatic rt_pkg::fix_t scale_add(rt_pkg::fix_t o, rt_pkg::fix_t d,
                                             rt_pkg::fix_t t);
    logic signed [63:0] prod;
    prod = d * t;
    return o + prod[`RT_FRAC_BITS +: 32];
  endfunction

  assign dz = ray.dir.z;
  assign oz = ray.orig.z;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= rt_pkg::C_IDLE;
      idx      <= '0;
      found    <= 1'b0;
      best_t   <= '0;
      best_z   <= '0;
      best_idx <= '0;
    end else begin
      case (state)
        rt_pkg::C_IDLE: begin
          if (core_start) begin
            idx   <= '0;
            found <= 1'b0;
            if (dz == '0) begin
              state <= rt_pkg::C_DONE;  // Parallel to every plane.
            end else begin
              state <= rt_pkg::C_NEXT;
            end
          end
        end
        rt_pkg::C_NEXT: begin
          state <= rt_pkg::C_DIV;
        end
        rt_pkg::C_DIV: begin
          if (div_done) begin
            // Strict compare keeps the lower index on a tie.
            if (div_quot > 0 && (!found || div_quot < best_t)) begin
              found    <= 1'b1;
              best_t   <= div_quot;
              best_z   <= rd_z;
              best_idx <= idx;
            end
            if (idx == LAST_IDX) begin
              state <= rt_pkg::C_DONE;
            end else begin
              idx   <= idx + 1'b1;
              state <= rt_pkg::C_NEXT;
            end
          end
        end
        rt_pkg::C_DONE: begin
          state <= rt_pkg::C_IDLE;
        end
        default: begin
          state <= rt_pkg::C_IDLE;
        end
      endcase
    end
  end

  assign rd_idx    = idx;
  assign div_start = (state == rt_pkg::C_NEXT);
  assign div_num   = rd_z - oz;
  assign div_den   = dz;
  assign core_done = (state == rt_pkg::C_DONE);

  always_comb begin
    core_hit     = '0;
    core_hit.sid = `RT_MISS_SID;
    if (found) begin
      core_hit.point.x = scale_add(ray.orig.x, ray.dir.x, best_t);
      core_hit.point.y = scale_add(ray.orig.y, ray.dir.y, best_t);
      core_hit.point.z = best_z;  // Exact plane height.
      core_hit.norm.z  = (dz > 0) ? -FIX_ONE : FIX_ONE;
      core_hit.sid     = rt_pkg::sid_t'(best_idx);
    end
  end

endmodule

/* hdl/ic_mem_manager.sv */
`timescale 1ns/10ps

module ic_mem_manager (
  input  logic         clk,
  input  logic         rst,
  input  logic         ray_valid,
  input  rt_pkg::ray_t ray_in,
  input  logic         core_done,
  input  rt_pkg::hit_t core_hit,
  output logic         busy,
  output logic         core_start,
  output rt_pkg::ray_t held_ray,
  output logic         result_valid,
  output rt_pkg::hit_t result_hit
);

  rt_pkg::mgr_state_t state;
  rt_pkg::mgr_state_t nxt_state;
  logic               ld_in;
  logic               ld_out;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= rt_pkg::IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    ld_in     = 1'b0;
    ld_out    = 1'b0;
    nxt_state = state;
    case (state)
      rt_pkg::BUSY: begin
        if (core_done) begin
          ld_out    = 1'b1;
          nxt_state = rt_pkg::IDLE;
        end
      end
      default: begin
        if (ray_valid) begin
          ld_in     = 1'b1;  // Strobes while busy never get here.
          nxt_state = rt_pkg::BUSY;
        end
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      held_ray     <= '0;
      result_hit   <= '0;
      core_start   <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      core_start   <= ld_in;
      result_valid <= ld_out;
      if (ld_in) begin
        held_ray <= ray_in;
      end
      if (ld_out) begin
        result_hit <= core_hit;
      end
    end
  end

  // Drops in the same cycle that result_valid is high.
  assign busy = (state == rt_pkg::BUSY);

endmodule

/* hdl/ray_intersect_top.sv */
`timescale 1ns/10ps

module ray_intersect_top (
  input  logic         clk,
  input  logic         rst,
  input  logic         ray_valid,
  input  rt_pkg::ray_t ray_in,
  input  logic         plane_wr,
  input  rt_pkg::pid_t plane_idx,
  input  rt_pkg::fix_t plane_z,
  output logic         busy,
  output logic         result_valid,
  output rt_pkg::tid_t result_tid,
  output rt_pkg::ray_t result_ray,
  output rt_pkg::hit_t result_hit
);

  logic         core_start;
  logic         core_done;
  rt_pkg::ray_t held_ray;
  rt_pkg::hit_t core_hit;
  rt_pkg::pid_t rd_idx;
  rt_pkg::fix_t rd_z;
  logic         div_start;
  logic         div_done;
  rt_pkg::fix_t div_num;
  rt_pkg::fix_t div_den;
  rt_pkg::fix_t div_quot;

  ic_mem_manager u_mgr (
    .clk          (clk),
    .rst          (rst),
    .ray_valid    (ray_valid),
    .ray_in       (ray_in),
    .core_done    (core_done),
    .core_hit     (core_hit),
    .busy         (busy),
    .core_start   (core_start),
    .held_ray     (held_ray),
    .result_valid (result_valid),
    .result_hit   (result_hit)
  );

  intersect_core u_core (
    .clk        (clk),
    .rst        (rst),
    .core_start (core_start),
    .ray        (held_ray),
    .rd_z       (rd_z),
    .div_done   (div_done),
    .div_quot   (div_quot),
    .rd_idx     (rd_idx),
    .div_start  (div_start),
    .div_num    (div_num),
    .div_den    (div_den),
    .core_done  (core_done),
    .core_hit   (core_hit)
  );

  ray_divider u_div (
    .clk       (clk),
    .rst       (rst),
    .div_start (div_start),
    .div_num   (div_num),
    .div_den   (div_den),
    .div_done  (div_done),
    .div_quot  (div_quot)
  );

  plane_table u_planes (
    .clk       (clk),
    .rst       (rst),
    .plane_wr  (plane_wr),
    .plane_idx (plane_idx),
    .plane_z   (plane_z),
    .rd_idx    (rd_idx),
    .rd_z      (rd_z)
  );

  // Thread id travels back with the held ray.
  assign result_tid = held_ray.tid;
  assign result_ray = held_ray;

endmodule

/* bench/ray_intersect_assertions.sv */
`timescale 1ns/10ps

module ray_intersect_assertions (
  input logic clk,
  input logic rst,
  input logic ray_valid,
  input logic busy,
  input logic core_start,
  input logic result_valid
);

  assert property (@(posedge clk) disable iff (rst) result_valid |=> !result_valid)
    else $error("result_valid high for more than one cycle");

  // Launch only in the cycle after an accepted strobe.
  assert property (@(posedge clk) disable iff (rst) core_start |-> $past(ray_valid && !busy))
    else $error("core_start without an accepted ray");

  assert property (@(posedge clk) disable iff (rst) result_valid |-> $past(busy))
    else $error("result_valid without a ray in flight");

  assert property (@(posedge clk) $fell(rst) |-> !busy && !result_valid)
    else $error("busy or result_valid high after reset");

endmodule

bind ray_intersect_top ray_intersect_assertions u_assert (
  .clk          (clk),
  .rst          (rst),
  .ray_valid    (ray_valid),
  .busy         (busy),
  .core_start   (core_start),
  .result_valid (result_valid)
);

/* bench/ray_intersect_checker.sv */
`timescale 1ns/10ps

module ray_intersect_checker (
  input  logic         clk,
  input  logic         result_valid,
  input  rt_pkg::tid_t result_tid,
  input  rt_pkg::ray_t result_ray,
  input  rt_pkg::hit_t result_hit,
  input  logic         exp_push,
  input  rt_pkg::ray_t exp_ray,
  input  rt_pkg::hit_t exp_hit,
  output int           chk_errors,
  output int           pending
);

  localparam int RESULT_LIMIT = 300;  // Cycles from launch to result.

  rt_pkg::ray_t ray_q [$];
  rt_pkg::hit_t hit_q [$];
  int           wait_cnt = 0;
  int           err_cnt = 0;

  assign chk_errors = err_cnt;

  task automatic compare_field(input string name, input logic [95:0] exp_v,
                               input logic [95:0] act_v);
    if (act_v !== exp_v) begin
      $display("FAILED %0t %s: expected %h, actual %h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    if (exp_push) begin
      ray_q.push_back(exp_ray);
      hit_q.push_back(exp_hit);
    end
    if (result_valid) begin
      wait_cnt = 0;
      if (ray_q.size() == 0) begin
        $display("Result for thread %0d with no ray outstanding", result_tid);
        err_cnt++;
      end else begin
        compare_field("result_tid", 96'(ray_q[0].tid), 96'(result_tid));
        compare_field("result_ray.tid", 96'(ray_q[0].tid), 96'(result_ray.tid));
        compare_field("result_ray.orig", ray_q[0].orig, result_ray.orig);
        compare_field("result_ray.dir", ray_q[0].dir, result_ray.dir);
        compare_field("result_hit.point", hit_q[0].point, result_hit.point);
        compare_field("result_hit.norm", hit_q[0].norm, result_hit.norm);
        compare_field("result_hit.sid", 96'(hit_q[0].sid), 96'(result_hit.sid));
        void'(ray_q.pop_front());
        void'(hit_q.pop_front());
      end
    end else if (ray_q.size() > 0) begin
      wait_cnt++;
      if (wait_cnt > RESULT_LIMIT) begin
        $display("No result for thread %0d within %0d cycles", ray_q[0].tid, RESULT_LIMIT);
        err_cnt++;
        wait_cnt = 0;
        void'(ray_q.pop_front());
        void'(hit_q.pop_front());
      end
    end
    pending = ray_q.size();
  end

endmodule

/* bench/ray_intersect_tb.sv */
`timescale 1ns/10ps

module ray_intersect_tb;

  localparam int IDLE_LIMIT = 400;  // Well above one full four-plane ray.

  logic         clk = 1'b0;
  logic         rst;
  logic         ray_valid;
  rt_pkg::ray_t ray_in;
  logic         plane_wr;
  rt_pkg::pid_t plane_idx;
  rt_pkg::fix_t plane_z;
  logic         busy;
  logic         result_valid;
  rt_pkg::tid_t result_tid;
  rt_pkg::ray_t result_ray;
  rt_pkg::hit_t result_hit;
  logic         exp_push;
  rt_pkg::ray_t exp_ray;
  rt_pkg::hit_t exp_hit;
  int           chk_errors;
  int           pending;
  int           errors = 0;

  always #10 clk = ~clk;

  ray_intersect_top DUT (.*);

  ray_intersect_checker u_chk (.*);

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < IDLE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("Timeout: busy still high after %0d cycles", IDLE_LIMIT);
      errors++;
    end
  endtask

  task automatic write_plane(input rt_pkg::pid_t idx, input rt_pkg::fix_t z);
    wait_idle();
    plane_wr  = 1'b1;
    plane_idx = idx;
    plane_z   = z;
    @(negedge clk);
    plane_wr = 1'b0;
  endtask

  task automatic launch_ray(input rt_pkg::ray_t ray, input rt_pkg::hit_t hit);
    rt_pkg::ray_t decoy;
    int           gap;
    decoy     = ray;
    decoy.tid = ~ray.tid;
    gap       = $urandom_range(3, 0);
    wait_idle();
    repeat (gap) @(negedge clk);
    ray_valid = 1'b1;
    ray_in    = ray;
    exp_push  = 1'b1;
    exp_ray   = ray;
    exp_hit   = hit;
    @(negedge clk);
    exp_push = 1'b0;
    if (!busy) begin
      $display("busy did not rise after the ray of thread %0d", ray.tid);
      errors++;
    end
    ray_in = decoy;  // Strobe while busy, must be dropped.
    @(negedge clk);
    ray_valid = 1'b0;
  endtask

  initial begin
    rt_pkg::ray_t r;
    rt_pkg::hit_t h;
    rt_pkg::pid_t pi;
    rt_pkg::fix_t z;
    int           fd;
    int           n;
    string        line;
    void'($urandom(19356));
    rst       = 1'b1;
    ray_valid = 1'b0;
    ray_in    = '0;
    plane_wr  = 1'b0;
    plane_idx = '0;
    plane_z   = '0;
    exp_push  = 1'b0;
    exp_ray   = '0;
    exp_hit   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (busy || result_valid) begin
      $display("busy or result_valid not low after reset");
      errors++;
    end
    fd = $fopen("bench/ray_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open bench/ray_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        h = '0;
        n = $fgets(line, fd);
        if (n > 0 && line[0] == "P") begin
          n = $sscanf(line, "P %h %h", pi, z);
          write_plane(pi, z);
        end else if (n > 0 && line[0] == "R") begin
          n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h %h", r.tid, r.orig.x,
                      r.orig.y, r.orig.z, r.dir.x, r.dir.y, r.dir.z, h.point.x,
                      h.point.y, h.point.z, h.norm.z, h.sid);
          if (n != 12) begin
            $display("Malformed ray line in the vectors file: %s", line);
            errors++;
          end else begin
            launch_ray(r, h);
          end
        end
      end
      $fclose(fd);
    end
    wait_idle();
    n = 0;
    while (pending > 0 && n < IDLE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pending > 0) begin
      $display("Timeout: %0d results still missing after %0d cycles", pending, IDLE_LIMIT);
      errors++;
    end
    $display("Errors: %0d in checker, %0d in bench", chk_errors, errors);
    if (chk_errors + errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* bench/ray_vectors.txt */
# P idx z : plane write, z in hex Q16.16
# R tid ox oy oz dx dy dz px py pz nz sid : ray, expected point, normal z and sid (hex)
P 0 00050000
P 1 ffec0000
P 2 ffec0000
P 3 ffec0000
R 01 00010000 00020000 00000000 00008000 ffffc000 00010000 00038000 0000c000 00050000 ffff0000 00000000
R 02 00000000 00000000 000a0000 00010000 00000000 fffe0000 00028000 00000000 00050000 00010000 00000000
P 0 00080000
P 1 fffd0000
P 2 00040000
P 3 00040000
R 07 00000000 00000000 00010000 00004000 00000000 00008000 00018000 00000000 00040000 ffff0000 00000002
R 08 00010000 00010000 00060000 00000000 ffff0000 ffff0000 00010000 ffff0000 00040000 00010000 00000002
R 09 00010000 00010000 00010000 00010000 00000000 00000000 00000000 00000000 00000000 00000000 ffffffff
R 0a 00000000 00000000 00080000 00000000 00000000 00010000 00000000 00000000 00000000 00000000 ffffffff
P 0 ffec0000
P 1 00020000
P 2 ffec0000
P 3 00070000
R 1f 00000000 00000000 00000000 00010000 00010000 00010000 00020000 00020000 00020000 ffff0000 00000001
P 1 ffec0000
R 1e 00000000 00000000 00000000 00010000 00010000 00010000 00070000 00070000 00070000 ffff0000 00000003

/* verilog.f */
+incdir+hdl
hdl/rt_pkg.sv
hdl/plane_table.sv
hdl/ray_divider.sv
hdl/intersect_core.sv
hdl/ic_mem_manager.sv
hdl/ray_intersect_top.sv
bench/ray_intersect_assertions.sv
bench/ray_intersect_checker.sv
bench/ray_intersect_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module ray_intersect_tb -o ray_sim
./obj_dir/ray_sim 2>&1 | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
